// ==== spi_bram_params.svh ====
/*
  Build-time sizes for the SPI to block RAM slave.
  SPI_MEM_AW may be set from 4 to 16. The RAM then holds 2**SPI_MEM_AW bytes
  and the 16 bit SPI address wraps at that size.
  SPI_SYNC_STAGES must be 2 or more. Every extra stage adds one clk cycle
  of delay between the pins and the edge strobes.
*/
`ifndef SPI_BRAM_PARAMS_SVH
`define SPI_BRAM_PARAMS_SVH

// ram address width in bits, 1024 bytes by default
`define SPI_MEM_AW 10

// flops per pin ahead of sclk edge detection
`define SPI_SYNC_STAGES 2

`endif

// ==== spi_bram_pkg.sv ====
/*
  Shared types of the SPI to block RAM slave.
  Commands are 8 bits wide and all other values are ignored by the decoder.
  The request address is always 16 bits. The RAM uses only its low bits.
*/
`default_nettype none

package spi_bram_pkg;

  // first byte of every frame
  typedef enum logic [7:0] {
    cmd_write = 8'h00, // addr hi, addr lo, data...
    cmd_read  = 8'h01  // addr hi, addr lo, dummy, data...
  } spi_cmd_e;

  // which byte of the frame is being shifted in
  typedef enum logic [2:0] {
    st_cmd,
    st_addr_hi,
    st_addr_lo,
    st_dummy,   // read only, first fetch goes out at its end
    st_data,
    st_ignore   // unknown command, wait for spi_csn high
  } frame_state_e;

  // synchronized spi lines, all in the clk domain
  typedef struct packed {
    logic sel;  // spi_csn low
    logic rise; // one cycle per rising sclk
    logic fall; // one cycle per falling sclk
    logic mosi; // valid together with rise
  } spi_line_t;

  // decoder to ram, rd and wr are single pulses
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } mem_req_t;

  // ram to miso shifter
  typedef struct packed {
    logic       rvalid; // one cycle after rd
    logic [7:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== spi_input_sync.sv ====
/*
  Brings sclk, mosi and spi_csn into the clk domain.
  clk must run at least eight times faster than sclk.
  A pin change is seen in line after SPI_SYNC_STAGES + 1 clk cycles.
  Edge strobes are only produced while the chip select is active.
*/
`default_nettype none
`include "spi_bram_params.svh"

module spi_input_sync (
  input  logic                   clk,
  input  logic                   csn,
  input  logic                   sclk,
  input  logic                   mosi,
  input  logic                   spi_csn,
  output spi_bram_pkg::spi_line_t line
);

  logic [`SPI_SYNC_STAGES-1:0] sclk_sync; // metastability chains
  logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
  logic [`SPI_SYNC_STAGES-1:0] cs_sync;
  logic                        sclk_last; // previous synced sclk
  logic                        sclk_s;
  logic                        mosi_s;
  logic                        sel_s;

  assign sclk_s = sclk_sync[`SPI_SYNC_STAGES-1];
  assign mosi_s = mosi_sync[`SPI_SYNC_STAGES-1];
  assign sel_s  = ~cs_sync[`SPI_SYNC_STAGES-1]; // chip select is active low

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1; // deselected out of reset
      sclk_last <= 1'b0;
      line      <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-2:0], sclk};
      mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], mosi};
      cs_sync   <= {cs_sync[`SPI_SYNC_STAGES-2:0], spi_csn};
      sclk_last <= sclk_s;
      line.sel  <= sel_s;
      line.rise <= sel_s & sclk_s & ~sclk_last; // 0 -> 1
      line.fall <= sel_s & ~sclk_s & sclk_last; // 1 -> 0
      line.mosi <= mosi_s;                      // lines up with rise
    end
  end

endmodule

`default_nettype wire

// ==== spi_frame_decoder.sv ====
/*
  Frame decoder of the SPI slave.
  Bytes arrive MSB first and complete on the rise strobe of their eighth bit.
  Requests go out one cycle after that strobe and the address then steps.
  Read frames fetch one byte ahead, starting at the end of the dummy byte.
  Dropping sel returns to st_cmd and discards a partly shifted byte.
*/
`default_nettype none

module spi_frame_decoder (
  input  logic                    clk,
  input  logic                    csn,
  input  spi_bram_pkg::spi_line_t line,
  output spi_bram_pkg::mem_req_t  req
);

  spi_bram_pkg::frame_state_e state;
  spi_bram_pkg::spi_cmd_e     cmd_q;     // latched command
  logic [2:0]                 bit_cnt;   // bits of current byte
  logic [6:0]                 shreg;     // first seven bits of a byte
  logic [7:0]                 byte_now;  // byte incl. the bit on line
  logic                       byte_done;
  logic                       issue_rd;
  logic                       issue_wr;
  logic [15:0]                addr_q;    // running frame address
  logic                       req_rd;
  logic                       req_wr;
  logic [15:0]                req_addr;
  logic [7:0]                 req_wdata;

  assign byte_now  = {shreg, line.mosi};
  assign byte_done = line.rise && (bit_cnt == 3'd7);

  // read after dummy and after every data byte of a read frame
  assign issue_rd = byte_done &&
                    ((state == spi_bram_pkg::st_dummy) ||
                     (state == spi_bram_pkg::st_data && cmd_q == spi_bram_pkg::cmd_read));
  assign issue_wr = byte_done && (state == spi_bram_pkg::st_data) &&
                    (cmd_q == spi_bram_pkg::cmd_write);

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      state   <= spi_bram_pkg::st_cmd;
      cmd_q   <= spi_bram_pkg::cmd_write;
      bit_cnt <= 3'd0;
      req_rd  <= 1'b0;
      req_wr  <= 1'b0;
    end
    else if (!line.sel)
    begin
      state   <= spi_bram_pkg::st_cmd; // frame over, start clean
      bit_cnt <= 3'd0;
      req_rd  <= 1'b0;
      req_wr  <= 1'b0;
    end
    else
    begin
      req_rd <= issue_rd; // single cycle pulses
      req_wr <= issue_wr;
      if (line.rise)
        bit_cnt <= bit_cnt + 3'd1; // wraps mod 8
      if (byte_done)
      begin
        case (state)
          spi_bram_pkg::st_cmd:
          begin
            if (byte_now == spi_bram_pkg::cmd_write || byte_now == spi_bram_pkg::cmd_read)
            begin
              cmd_q <= spi_bram_pkg::spi_cmd_e'(byte_now);
              state <= spi_bram_pkg::st_addr_hi;
            end
            else
              state <= spi_bram_pkg::st_ignore; // rest of frame dropped
          end
          spi_bram_pkg::st_addr_hi:
            state <= spi_bram_pkg::st_addr_lo;
          spi_bram_pkg::st_addr_lo:
          begin
            if (cmd_q == spi_bram_pkg::cmd_read)
              state <= spi_bram_pkg::st_dummy;
            else
              state <= spi_bram_pkg::st_data;
          end
          spi_bram_pkg::st_dummy:
            state <= spi_bram_pkg::st_data;
          spi_bram_pkg::st_data,
          spi_bram_pkg::st_ignore:
            state <= state; // stays until sel drops
          default:
            state <= spi_bram_pkg::st_cmd;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (line.rise)
      shreg <= byte_now[6:0]; // msb first
    if (byte_done && state == spi_bram_pkg::st_addr_hi)
      addr_q[15:8] <= byte_now;
    if (byte_done && state == spi_bram_pkg::st_addr_lo)
      addr_q[7:0] <= byte_now;
    if (issue_rd || issue_wr)
    begin
      req_addr <= addr_q;          // current address goes out
      addr_q   <= addr_q + 16'd1;  // then step, ram wraps it
    end
    if (issue_wr)
      req_wdata <= byte_now;
  end

  assign req = '{rd: req_rd, wr: req_wr, addr: req_addr, wdata: req_wdata};

endmodule

`default_nettype wire

// ==== spi_byte_ram.sv ====
/*
  Single-port byte RAM behind the SPI slave.
  Only the low SPI_MEM_AW address bits are used, so addresses alias.
  Reads are registered with exactly one cycle of latency.
  Contents come up undefined after power on.
*/
`default_nettype none
`include "spi_bram_params.svh"

module spi_byte_ram (
  input  logic                   clk,
  input  logic                   csn,
  input  spi_bram_pkg::mem_req_t req,
  output spi_bram_pkg::mem_rsp_t rsp
);

  localparam int unsigned DEPTH = 1 << `SPI_MEM_AW;

  logic [7:0]             mem [DEPTH];
  logic [`SPI_MEM_AW-1:0] addr;     // wrapped index
  logic [7:0]             rdata_q;
  logic                   rvalid_q;

  assign addr = req.addr[`SPI_MEM_AW-1:0];

  always_ff @(posedge clk)
  begin
    if (req.wr)
      mem[addr] <= req.wdata; // lands at the wr edge
    if (req.rd)
      rdata_q <= mem[addr];
  end

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= req.rd; // marks rdata_q
  end

  assign rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== spi_miso_shifter.sv ====
/*
  miso output stage of the SPI slave, mode 0.
  A fetched byte waits as pending until the next byte boundary, which is
  the eighth fall strobe of a byte. It is then shifted out MSB first.
  sclk half period must be 6 clk cycles or more for the fetch to arrive.
  miso is forced low while miso_en is low, the pad tri-state is off chip.
*/
`default_nettype none

module spi_miso_shifter (
  input  logic                    clk,
  input  logic                    csn,
  input  spi_bram_pkg::spi_line_t line,
  input  spi_bram_pkg::mem_rsp_t  rsp,
  output logic                    miso,
  output logic                    miso_en
);

  logic [2:0] fall_cnt;  // falls seen in this byte
  logic       pend_q;    // a fetched byte waits
  logic [7:0] pend_byte;
  logic [7:0] shreg;     // msb drives miso
  logic       boundary;

  assign boundary = line.fall && (fall_cnt == 3'd7);

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      fall_cnt <= 3'd0;
      pend_q   <= 1'b0;
      miso_en  <= 1'b0;
    end
    else
    begin
      miso_en <= line.sel; // sel delayed by one
      if (!line.sel)
      begin
        fall_cnt <= 3'd0;
        pend_q   <= 1'b0;
      end
      else
      begin
        if (line.fall)
          fall_cnt <= fall_cnt + 3'd1;
        if (boundary)
          pend_q <= 1'b0;  // consumed
        if (rsp.rvalid)
          pend_q <= 1'b1;  // new fetch wins
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rsp.rvalid)
      pend_byte <= rsp.rdata;
    if (!line.sel)
      shreg <= 8'h00;
    else if (boundary)
      shreg <= pend_q ? pend_byte : 8'h00; // zeros outside read data
    else if (line.fall)
      shreg <= {shreg[6:0], 1'b0};
  end

  assign miso = miso_en & shreg[7];

endmodule

`default_nettype wire

// ==== spi_bram_top.sv ====
/*
  SPI slave with byte access to an on-chip block RAM.
  Frames: write 00 ah al data..., read 01 ah al dummy data...
  All SPI pins are sampled by clk, which must be at least eight times sclk.
  miso_en tells the board when to enable the miso pad driver.
*/
`default_nettype none

module spi_bram_top (
  input  logic clk,
  input  logic csn,     // system reset, active high
  input  logic sclk,
  input  logic mosi,
  input  logic spi_csn, // spi chip select, active low
  output logic miso,
  output logic miso_en
);

  spi_bram_pkg::spi_line_t line; // synced pins and edge strobes
  spi_bram_pkg::mem_req_t  req;  // decoder to ram
  spi_bram_pkg::mem_rsp_t  rsp;  // ram to shifter

  spi_input_sync u_sync (
    .clk     (clk),
    .csn     (csn),
    .sclk    (sclk),
    .mosi    (mosi),
    .spi_csn (spi_csn),
    .line    (line)
  );

  spi_frame_decoder u_decoder (
    .clk  (clk),
    .csn  (csn),
    .line (line),
    .req  (req)
  );

  spi_byte_ram u_ram (
    .clk (clk),
    .csn (csn),
    .req (req),
    .rsp (rsp)
  );

  spi_miso_shifter u_shifter (
    .clk     (clk),
    .csn     (csn),
    .line    (line),
    .rsp     (rsp),
    .miso    (miso),
    .miso_en (miso_en)
  );

endmodule

`default_nettype wire

// ==== spi_bram_checker.sv ====
/*
  Pin level checker of the SPI slave.
  In read frames miso is sampled at every rising sclk after the 32 header
  edges and each byte is compared with exp_data, byte i at [8*i +: 8].
  miso_en must follow spi_csn within EN_LAG clk cycles.
  test_name is written by the testbench before each test.
*/
`default_nettype none

module spi_bram_checker (
  input  logic         clk,
  input  logic         csn,
  input  logic         sclk,
  input  logic         spi_csn,
  input  logic         miso,
  input  logic         miso_en,
  input  logic         rd_check, // frame under way is a read
  input  logic [4:0]   exp_len,  // data bytes to compare
  input  logic [127:0] exp_data,
  output int           err_cnt,
  output int           chk_cnt
);

  localparam int HDR_EDGES = 32; // cmd, addr hi, addr lo, dummy
  localparam int EN_LAG    = 8;  // sync chain plus output register

  string      test_name;
  logic       sclk_q;
  logic       spi_csn_q;
  logic       en_seen;           // one report per spi_csn phase
  int         edge_cnt;          // rising sclk edges in this frame
  int         got_cnt;
  int         stable_cnt;
  int         idx;
  logic [7:0] rx;

  always @(posedge clk)
  begin
    if (csn)
    begin
      sclk_q     = 1'b0;
      spi_csn_q  = 1'b1;
      en_seen    = 1'b0;
      stable_cnt = 0;
      err_cnt    = 0;
      chk_cnt    = 0;
    end
    else
    begin
      if (spi_csn && !spi_csn_q && rd_check && got_cnt != int'(exp_len))
      begin
        $display("test %s: read frame ended after %0d of %0d data bytes",
                 test_name, got_cnt, exp_len);
        err_cnt++;
      end
      if (spi_csn != spi_csn_q)
      begin
        stable_cnt = 0; // frame starts or ends
        en_seen    = 1'b0;
        edge_cnt   = 0;
        got_cnt    = 0;
      end
      else if (stable_cnt < EN_LAG)
        stable_cnt++;
      if (!spi_csn && sclk && !sclk_q)
      begin
        rx = {rx[6:0], miso}; // msb first
        if (rd_check && edge_cnt >= HDR_EDGES && (edge_cnt - HDR_EDGES) % 8 == 7)
        begin
          idx = (edge_cnt - HDR_EDGES) / 8;
          if (idx >= int'(exp_len))
          begin
            $display("test %s: read frame ran past its %0d data bytes", test_name, exp_len);
            err_cnt++;
          end
          else
          begin
            got_cnt++;
            chk_cnt++;
            if (rx !== exp_data[8*idx +: 8])
            begin
              $display("CHECK FAILED test %s byte %0d: expected %02h, actual %02h",
                       test_name, idx, exp_data[8*idx +: 8], rx);
              err_cnt++;
            end
          end
        end
        edge_cnt++;
      end
      if (stable_cnt >= EN_LAG && !en_seen && miso_en == spi_csn)
      begin
        if (spi_csn)
          $display("test %s: miso_en is high while spi_csn is high", test_name);
        else
          $display("test %s: miso_en stays low inside a frame", test_name);
        err_cnt++;
        en_seen = 1'b1;
      end
      sclk_q    = sclk;
      spi_csn_q = spi_csn;
    end
  end

endmodule

`default_nettype wire

// ==== tb_spi_bram.sv ====
/*
  Testbench of the SPI block RAM slave in SPI mode 0, sclk half period 8 clk.
  Frames are random from $urandom with a fixed seed, so every run repeats.
  Bursts hold at most 16 data bytes and reads touch written bytes only.
  Read data is compared by spi_bram_checker against the model kept here.
*/
`default_nettype none
`include "spi_bram_params.svh"

module tb_spi_bram;

  localparam int MEM_SIZE = 1 << `SPI_MEM_AW;
  localparam int HALF     = 8;                                  // sclk half period in clk
  localparam int FRAME    = (5 + 16) * 8 * 2 * HALF + 4 * HALF; // longest frame plus gaps
  localparam int TIMEOUT  = 113 * FRAME + 1000;                 // 13 directed, 100 random

  logic         clk;
  logic         csn       = 1'b1;
  logic         sclk      = 1'b0;
  logic         mosi      = 1'b0;
  logic         spi_csn   = 1'b1;
  logic         miso;
  logic         miso_en;
  logic         rd_check  = 1'b0; // checker compares this frame
  logic [4:0]   exp_len   = '0;
  logic [127:0] exp_data  = '0;
  int           err_cnt;
  int           chk_cnt;
  int           cycle_cnt;
  int           err_base;
  int           n_pass;
  int           n_fail;
  logic [7:0]   model [MEM_SIZE]; // ram contents as the master sees them
  bit           valid [MEM_SIZE]; // set once a byte is written
  logic [7:0]   wbuf [16];        // bytes sent after the header
  int           written_q [$];    // start indexes of write bursts
  logic [15:0]  addr;
  int           n;
  int           k;
  int           m;

  spi_bram_top i_dut (.*);

  spi_bram_checker i_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT)
    begin
      $display("timeout, frames still running after %0d clk cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int wrap(input logic [15:0] a);
    return int'(a) % MEM_SIZE; // only the low address bits pick a byte
  endfunction

  task automatic send_bits(input logic [7:0] b, input int nbits);
    int i;
    for (i = 7; i > 7 - nbits; i--)
    begin
      mosi <= b[i]; // msb first, changes with sclk low
      repeat (HALF) @(posedge clk);
      sclk <= 1'b1;
      repeat (HALF) @(posedge clk);
      sclk <= 1'b0;
    end
  endtask

  // header, then nb bytes of wbuf, then cut bits of a byte that never ends
  task automatic frame(input logic [7:0] cmd, input logic [15:0] a, input int nb,
                       input int cut);
    int i;
    spi_csn <= 1'b0;
    repeat (HALF) @(posedge clk);
    send_bits(cmd, 8);
    send_bits(a[15:8], 8);
    send_bits(a[7:0], 8);
    if (cmd == 8'h01)
      send_bits(8'($urandom), 8); // dummy byte
    for (i = 0; i < nb; i++)
      send_bits(wbuf[i], 8);
    if (cut > 0)
      send_bits(8'($urandom), cut);
    repeat (HALF) @(posedge clk);
    spi_csn <= 1'b1;
    repeat (2 * HALF) @(posedge clk);
  endtask

  task automatic write_mem(input logic [15:0] a, input int nb);
    int i;
    for (i = 0; i < nb; i++)
    begin
      wbuf[i] = 8'($urandom);
      model[wrap(a + 16'(i))] = wbuf[i];
      valid[wrap(a + 16'(i))] = 1'b1;
    end
    frame(8'h00, a, nb, 0);
  endtask

  task automatic read_mem(input logic [15:0] a, input int nb);
    logic [127:0] e;
    int           i;
    e = '0;
    for (i = 0; i < nb; i++)
      e[8*i +: 8] = model[wrap(a + 16'(i))]; // wraps like the ram
    exp_data <= e;
    exp_len  <= 5'(nb);
    rd_check <= 1'b1;
    @(posedge clk);
    frame(8'h01, a, nb, 0);
    rd_check <= 1'b0;
  endtask

  task automatic end_test();
    @(negedge clk); // checker counts are settled here
    if (err_cnt == err_base)
    begin
      n_pass++;
      $display("test %s: pass", i_checker.test_name);
    end
    else
    begin
      n_fail++;
      $display("test %s: fail with %0d errors", i_checker.test_name, err_cnt - err_base);
    end
    err_base = err_cnt;
    @(posedge clk);
  endtask

  initial
  begin
    void'($urandom(32'hf53e));
    repeat (5) @(posedge clk);
    csn <= 1'b0;
    repeat (4) @(posedge clk);

    i_checker.test_name = "single_write";
    addr = 16'($urandom);
    write_mem(addr, 1);
    read_mem(addr, 1);
    end_test();

    i_checker.test_name = "burst";
    addr = 16'($urandom);
    n = 1 + $urandom % 16;
    write_mem(addr, n);
    read_mem(addr, n);
    end_test();

    i_checker.test_name = "wrap_alias";
    n = 4 + $urandom % 13;
    k = 1 + $urandom % (n - 1); // bytes below the top
    write_mem(16'(($urandom & ~(MEM_SIZE - 1)) | (MEM_SIZE - k)), n);
    read_mem(16'(($urandom & ~(MEM_SIZE - 1)) | (MEM_SIZE - k)), n); // other high bits
    read_mem(16'($urandom & ~(MEM_SIZE - 1)), n - k);                // wrapped tail at 0
    end_test();

    i_checker.test_name = "abort_write";
    addr = 16'($urandom);
    write_mem(addr, 1);
    frame(8'h00, addr, 0, 1 + $urandom % 7); // spi_csn rises mid data byte
    read_mem(addr, 1);
    end_test();

    i_checker.test_name = "bad_command";
    addr = 16'($urandom);
    write_mem(addr, 2);
    wbuf[0] = ~wbuf[0];
    wbuf[1] = ~wbuf[1];
    frame(8'(2 + $urandom % 254), addr, 2, 0);
    read_mem(addr, 2);
    end_test();

    i_checker.test_name = "random_mix";
    repeat (100)
    begin
      n = 1 + $urandom % 16;
      if (written_q.size() == 0 || $urandom % 2 == 0)
      begin
        addr = 16'($urandom);
        write_mem(addr, n);
        written_q.push_back(wrap(addr));
      end
      else
      begin
        k = written_q[$urandom % written_q.size()];
        m = 1;
        while (m < n && valid[(k + m) % MEM_SIZE])
          m++; // stop at the first unwritten byte
        read_mem(16'(($urandom & ~(MEM_SIZE - 1)) | k), m);
      end
    end
    end_test();

    @(negedge clk);
    if (chk_cnt == 0)
    begin
      $display("no read data reached the checker");
      n_fail++;
    end
    $display("summary: %0d passed, %0d failed, %0d bytes compared, %0d errors",
             n_pass, n_fail, chk_cnt, err_cnt);
    if (n_fail == 0 && err_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
spi_bram_pkg.sv
spi_input_sync.sv
spi_frame_decoder.sv
spi_byte_ram.sv
spi_miso_shifter.sv
spi_bram_top.sv
spi_bram_checker.sv
tb_spi_bram.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_spi_bram
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
